/* rtl/cmc_pkg.sv */
////////////////////////////////////////////////////////////////////////////
// Widths and types shared by the controller. The block width equals the
// AXI data width, and only XLEN of 32 is handled.
////////////////////////////////////////////////////////////////////////////

package cmc_pkg;

    ////////////////////////////////////////////////////////////////////////////
    // Widths
    ////////////////////////////////////////////////////////////////////////////

    // Control side word width
    localparam int XLEN = 32;

    // Cache block width, same as the memory data bus
    localparam int BLOCK_W = 128;

    // Words per block
    localparam int LANES = BLOCK_W / XLEN;

    // First address bit of the word lane inside a block
    localparam int OFFSET_LSB = 2;

    ////////////////////////////////////////////////////////////////////////////
    // Data types
    ////////////////////////////////////////////////////////////////////////////

    // One control word and its byte enables
    typedef logic [XLEN-1:0] word_t;
    typedef logic [XLEN/8-1:0] word_strb_t;

    // A whole cache block and its byte enables
    typedef logic [BLOCK_W-1:0] block_t;
    typedef logic [BLOCK_W/8-1:0] block_strb_t;

    // Word lane inside a block, taken from address bits 3:2
    typedef logic [$clog2(LANES)-1:0] lane_t;

endpackage

/* rtl/fifo_if.sv */
////////////////////////////////////////////////////////////////////////////
// Push/pull FIFO bundle. Push is dropped when full, pull needs not empty.
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/10ps

interface fifo_if #(
    parameter type T = logic
) ();

    // Write side
    logic push;
    logic full;
    T     data_in;

    // Read side, head entry is visible on data_out
    logic pull;
    logic empty;
    logic aempty;
    T     data_out;

    // User of the queue
    modport producer (output push, pull, data_in,
                      input  full, empty, aempty, data_out);

    // Storage itself
    modport fifo (input  push, pull, data_in,
                  output full, empty, aempty, data_out);

endinterface

/* rtl/sync_fifo.sv */
////////////////////////////////////////////////////////////////////////////
// Single clock FIFO with the head shown combinationally on data_out.
// DEPTH must be a power of two so that the pointers wrap on their own.
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/10ps

module sync_fifo #(
    parameter type T     = logic,
    parameter int  DEPTH = 4
) (
    input  logic  aclk,
    input  logic  aresetn,
    fifo_if.fifo  f
);

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    // Storage, payload only, no reset
    T mem [DEPTH];

    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;
    logic             wr_en;
    logic             rd_en;

    // Push is dropped when full
    assign wr_en = f.push && !f.full;
    assign rd_en = f.pull && !f.empty;

    ////////////////////////////////////////////////////////////////////////////
    // Pointers and occupancy
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge aclk or negedge aresetn) begin
        if (!aresetn) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (wr_en) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (rd_en) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            // Simultaneous push and pull keep the count
            case ({wr_en, rd_en})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    always_ff @(posedge aclk) begin
        if (wr_en) begin
            mem[wr_ptr] <= f.data_in;
        end
    end

    // Flags straight from the count
    assign f.full     = (count == CNT_W'(DEPTH));
    assign f.empty    = (count == '0);
    assign f.aempty   = (count == CNT_W'(1));
    assign f.data_out = mem[rd_ptr];

    ////////////////////////////////////////////////////////////////////////////
    // Usage checks on the producer
    ////////////////////////////////////////////////////////////////////////////

    ap_no_push_full: assert property (@(posedge aclk) disable iff (!aresetn)
        !(f.push && f.full))
        else $error("sync_fifo: push while full, entry lost");

    ap_no_pull_empty: assert property (@(posedge aclk) disable iff (!aresetn)
        !(f.pull && f.empty))
        else $error("sync_fifo: pull while empty");

endmodule

/* rtl/rd_channel.sv */
////////////////////////////////////////////////////////////////////////////
// Read path. Completions must come back in request order and single beat,
// at most OSTD_NUM reads can be in flight.
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/10ps

module rd_channel #(
    parameter int ADDR_W   = 10,
    parameter int OSTD_NUM = 4
) (
    input  logic                aclk,
    input  logic                aresetn,
    // Control side read address
    input  logic                mst_arvalid,
    output logic                mst_arready,
    input  logic [ADDR_W-1:0]   mst_araddr,
    input  logic [3:0]          mst_arcache,
    // Control side completion
    output logic                mst_rvalid,
    input  logic                mst_rready,
    output logic                mst_rcache,
    output logic [ADDR_W-1:0]   mst_raddr,
    output cmc_pkg::block_t     mst_rdata_blk,
    output cmc_pkg::word_t      mst_rdata,
    // Memory side
    output logic                mem_arvalid,
    input  logic                mem_arready,
    output logic [ADDR_W-1:0]   mem_araddr,
    input  logic                mem_rvalid,
    output logic                mem_rready,
    input  cmc_pkg::block_t     mem_rdata
);

    import cmc_pkg::*;

    // Address bits dropped to reach the block boundary
    localparam int BLK_LSB = $clog2(BLOCK_W / 8);

    // What a completion needs back from its request
    typedef struct packed {
        logic              io;
        logic [ADDR_W-1:0] addr;
    } rd_tag_t;

    fifo_if #(.T(rd_tag_t)) tag_q ();

    lane_t rd_lane;

    ////////////////////////////////////////////////////////////////////////////
    // Request side
    ////////////////////////////////////////////////////////////////////////////

    // Both sides stall once OSTD_NUM reads are pending
    assign mem_arvalid = mst_arvalid && !tag_q.full;
    assign mst_arready = mem_arready && !tag_q.full;
    assign mem_araddr  = {mst_araddr[ADDR_W-1:BLK_LSB], {BLK_LSB{1'b0}}};

    // Tag written on the accepting edge, arcache[1] marks an IO access
    assign tag_q.push         = mst_arvalid && mst_arready;
    assign tag_q.data_in.io   = mst_arcache[1];
    assign tag_q.data_in.addr = mst_araddr;

    sync_fifo #(
        .T     (rd_tag_t),
        .DEPTH (OSTD_NUM)
    ) u_tag_fifo (
        .aclk    (aclk),
        .aresetn (aresetn),
        .f       (tag_q)
    );

    ////////////////////////////////////////////////////////////////////////////
    // Completion side
    ////////////////////////////////////////////////////////////////////////////

    // Zero latency, handshake passes straight through
    assign mst_rvalid = mem_rvalid;
    assign mem_rready = mst_rready;
    assign tag_q.pull = mem_rvalid && mem_rready;

    // Head tag selects the word inside the returned block
    assign rd_lane       = tag_q.data_out.addr[OFFSET_LSB +: $bits(lane_t)];
    assign mst_rdata     = mem_rdata[rd_lane * XLEN +: XLEN];
    assign mst_rdata_blk = mem_rdata;
    assign mst_raddr     = tag_q.data_out.addr;
    // No stale IO flag when nothing is pending
    assign mst_rcache    = tag_q.empty ? 1'b0 : tag_q.data_out.io;

    // Memory answering a read that was never issued
    ap_rvalid_has_tag: assert property (@(posedge aclk) disable iff (!aresetn)
        mem_rvalid |-> !tag_q.empty)
        else $error("rd_channel: read data without a pending request");

endmodule

/* rtl/wr_channel.sv */
////////////////////////////////////////////////////////////////////////////
// Write path, one single beat per 32-bit write. Keep fewer than OSTD_NUM
// write addresses ahead of their data, a full offset FIFO also stalls W.
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/10ps

module wr_channel #(
    parameter int ADDR_W   = 10,
    parameter int OSTD_NUM = 4
) (
    input  logic                  aclk,
    input  logic                  aresetn,
    // Control side address
    input  logic                  mst_awvalid,
    output logic                  mst_awready,
    input  logic [ADDR_W-1:0]     mst_awaddr,
    // Control side data
    input  logic                  mst_wvalid,
    output logic                  mst_wready,
    input  cmc_pkg::word_t        mst_wdata,
    input  cmc_pkg::word_strb_t   mst_wstrb,
    // Memory side address
    output logic                  mem_awvalid,
    input  logic                  mem_awready,
    output logic [ADDR_W-1:0]     mem_awaddr,
    // Memory side data
    output logic                  mem_wvalid,
    input  logic                  mem_wready,
    output cmc_pkg::block_t       mem_wdata,
    output cmc_pkg::block_strb_t  mem_wstrb
);

    import cmc_pkg::*;

    localparam int BLK_LSB = $clog2(BLOCK_W / 8);

    fifo_if #(.T(lane_t)) off_q ();

    lane_t aw_lane;
    lane_t wr_lane;
    logic  aw_acc;
    logic  w_acc;
    // Set while queued lanes feed the data path
    logic  push_r;

    ////////////////////////////////////////////////////////////////////////////
    // Pass-through, gated by offset FIFO room
    ////////////////////////////////////////////////////////////////////////////

    assign mem_awvalid = mst_awvalid && !off_q.full;
    assign mst_awready = mem_awready && !off_q.full;
    assign mem_awaddr  = {mst_awaddr[ADDR_W-1:BLK_LSB], {BLK_LSB{1'b0}}};

    assign mem_wvalid = mst_wvalid && !off_q.full;
    assign mst_wready = mem_wready && !off_q.full;
    // Same word in every lane, strobe picks the one that counts
    assign mem_wdata  = {LANES{mst_wdata}};

    assign aw_acc = mem_awvalid && mem_awready;
    assign w_acc  = mem_wvalid && mem_wready;

    ////////////////////////////////////////////////////////////////////////////
    // Offset FIFO
    ////////////////////////////////////////////////////////////////////////////

    assign aw_lane = mst_awaddr[OFFSET_LSB +: $bits(lane_t)];

    // Address ran ahead of its data, or older lanes are still queued
    assign off_q.push    = aw_acc && (!w_acc || push_r);
    // A beat consumes the oldest queued lane, if one is waiting
    assign off_q.pull    = w_acc && !off_q.empty;
    assign off_q.data_in = aw_lane;

    sync_fifo #(
        .T     (lane_t),
        .DEPTH (OSTD_NUM)
    ) u_off_fifo (
        .aclk    (aclk),
        .aresetn (aresetn),
        .f       (off_q)
    );

    always_ff @(posedge aclk or negedge aresetn) begin
        if (!aresetn) begin
            push_r <= 1'b0;
        end else begin
            if (aw_acc && !w_acc) begin
                push_r <= 1'b1;
            // Last queued lane drains with no new lane behind it
            end else if (off_q.aempty && off_q.pull && !off_q.push) begin
                push_r <= 1'b0;
            end
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Strobe placement
    ////////////////////////////////////////////////////////////////////////////

    // Oldest queued lane first, else the address on the bus now
    assign wr_lane = off_q.empty ? aw_lane : off_q.data_out;

    always_comb begin
        for (int i = 0; i < LANES; i++) begin
            if (lane_t'(i) == wr_lane) begin
                mem_wstrb[i*(XLEN/8) +: XLEN/8] = mst_wstrb;
            end else begin
                mem_wstrb[i*(XLEN/8) +: XLEN/8] = '0;
            end
        end
    end

    // A data beat needs a lane from somewhere
    ap_w_has_lane: assert property (@(posedge aclk) disable iff (!aresetn)
        (w_acc && off_q.empty) |-> mst_awvalid)
        else $error("wr_channel: data beat with no address to place it");

endmodule

/* rtl/cache_memctrl.sv */
////////////////////////////////////////////////////////////////////////////
// Cache to memory bridge, whole block reads and single word writes over
// single beat AXI4 INCR. IDs and responses are not carried.
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/10ps

module cache_memctrl #(
    // Address width on both sides
    parameter int ADDR_W   = 10,
    // Reads in flight, power of two
    parameter int OSTD_NUM = 4
) (
    input  logic                  aclk,
    input  logic                  aresetn,
    // Control read address
    input  logic                  mst_arvalid,
    output logic                  mst_arready,
    input  logic [ADDR_W-1:0]     mst_araddr,
    input  logic [3:0]            mst_arcache,
    // Control read completion
    output logic                  mst_rvalid,
    input  logic                  mst_rready,
    output logic                  mst_rcache,
    output logic [ADDR_W-1:0]     mst_raddr,
    output cmc_pkg::block_t       mst_rdata_blk,
    output cmc_pkg::word_t        mst_rdata,
    // Control write
    input  logic                  mst_awvalid,
    output logic                  mst_awready,
    input  logic [ADDR_W-1:0]     mst_awaddr,
    input  logic                  mst_wvalid,
    output logic                  mst_wready,
    input  cmc_pkg::word_t        mst_wdata,
    input  cmc_pkg::word_strb_t   mst_wstrb,
    output logic                  mst_bvalid,
    input  logic                  mst_bready,
    // Memory read
    output logic                  mem_arvalid,
    input  logic                  mem_arready,
    output logic [ADDR_W-1:0]     mem_araddr,
    input  logic                  mem_rvalid,
    output logic                  mem_rready,
    input  cmc_pkg::block_t       mem_rdata,
    // Memory write
    output logic                  mem_awvalid,
    input  logic                  mem_awready,
    output logic [ADDR_W-1:0]     mem_awaddr,
    output logic                  mem_wvalid,
    input  logic                  mem_wready,
    output cmc_pkg::block_t       mem_wdata,
    output cmc_pkg::block_strb_t  mem_wstrb,
    input  logic                  mem_bvalid,
    output logic                  mem_bready
);

    ////////////////////////////////////////////////////////////////////////////
    // Read path, AR and R
    ////////////////////////////////////////////////////////////////////////////

    rd_channel #(
        .ADDR_W   (ADDR_W),
        .OSTD_NUM (OSTD_NUM)
    ) u_rd (
        .aclk          (aclk),
        .aresetn       (aresetn),
        .mst_arvalid   (mst_arvalid),
        .mst_arready   (mst_arready),
        .mst_araddr    (mst_araddr),
        .mst_arcache   (mst_arcache),
        .mst_rvalid    (mst_rvalid),
        .mst_rready    (mst_rready),
        .mst_rcache    (mst_rcache),
        .mst_raddr     (mst_raddr),
        .mst_rdata_blk (mst_rdata_blk),
        .mst_rdata     (mst_rdata),
        .mem_arvalid   (mem_arvalid),
        .mem_arready   (mem_arready),
        .mem_araddr    (mem_araddr),
        .mem_rvalid    (mem_rvalid),
        .mem_rready    (mem_rready),
        .mem_rdata     (mem_rdata)
    );

    ////////////////////////////////////////////////////////////////////////////
    // Write path, AW and W
    ////////////////////////////////////////////////////////////////////////////

    // Offset FIFO sized like the read tag FIFO
    wr_channel #(
        .ADDR_W   (ADDR_W),
        .OSTD_NUM (OSTD_NUM)
    ) u_wr (
        .aclk        (aclk),
        .aresetn     (aresetn),
        .mst_awvalid (mst_awvalid),
        .mst_awready (mst_awready),
        .mst_awaddr  (mst_awaddr),
        .mst_wvalid  (mst_wvalid),
        .mst_wready  (mst_wready),
        .mst_wdata   (mst_wdata),
        .mst_wstrb   (mst_wstrb),
        .mem_awvalid (mem_awvalid),
        .mem_awready (mem_awready),
        .mem_awaddr  (mem_awaddr),
        .mem_wvalid  (mem_wvalid),
        .mem_wready  (mem_wready),
        .mem_wdata   (mem_wdata),
        .mem_wstrb   (mem_wstrb)
    );

    // Write response needs no tracking
    assign mst_bvalid = mem_bvalid;
    assign mem_bready = mst_bready;

endmodule

/* tb/tb_tests.svh */
////////////////////////////////////////////////////////////////////////////
// Directed tests. Each task starts and ends on a falling clock edge.
////////////////////////////////////////////////////////////////////////////

// Present a read and queue what its completion must return
task automatic drive_ar(input addr_t addr, input logic [3:0] cache);
    mst_arvalid = 1'b1;
    mst_araddr  = addr;
    mst_arcache = cache;
    exp_addr.push_back(addr);
    exp_io.push_back(cache[1]);
endtask

// Hold the read until accepted, drop it on the next falling edge
task automatic finish_ar(input addr_t addr);
    int n;
    n = 0;
    settle();
    while (!mst_arready && n < TIMEOUT) begin
        @(negedge aclk);
        settle();
        n++;
    end
    if (mst_arready) begin
        check_bit("mem_arvalid", mem_arvalid, 1'b1);
        check_word("mem_araddr", word_t'(mem_araddr), word_t'(addr & ~addr_t'(15)));
    end else begin
        timeout_fail("read address was never accepted");
    end
    @(negedge aclk);
    mst_arvalid = 1'b0;
endtask

task automatic issue_read(input addr_t addr, input logic [3:0] cache);
    drive_ar(addr, cache);
    finish_ar(addr);
endtask

task automatic wait_reads_done();
    int n;
    n = 0;
    settle();
    while (exp_addr.size() != 0 && n < TIMEOUT) begin
        @(negedge aclk);
        settle();
        n++;
    end
    if (exp_addr.size() != 0) begin
        timeout_fail("not every read completion arrived");
    end
    @(negedge aclk);
endtask

task automatic send_aw(input addr_t addr);
    int n;
    n = 0;
    mst_awvalid = 1'b1;
    mst_awaddr  = addr;
    settle();
    while (!mst_awready && n < TIMEOUT) begin
        @(negedge aclk);
        settle();
        n++;
    end
    if (mst_awready) begin
        check_bit("mem_awvalid", mem_awvalid, 1'b1);
        check_word("mem_awaddr", word_t'(mem_awaddr), word_t'(addr & ~addr_t'(15)));
    end else begin
        timeout_fail("write address was never accepted");
    end
    @(negedge aclk);
endtask

// Wait for the data beat and check lane copies and strobe lane
task automatic finish_w(input word_t d, input word_strb_t s, input lane_t lane);
    int n;
    n = 0;
    settle();
    while (!mst_wready && n < TIMEOUT) begin
        @(negedge aclk);
        settle();
        n++;
    end
    if (mst_wready) begin
        check_bit("mem_wvalid", mem_wvalid, 1'b1);
        check_block("mem_wdata", mem_wdata, {LANES{d}});
        check_strb("mem_wstrb", mem_wstrb, block_strb_t'(s) << (int'(lane) * 4));
    end else begin
        timeout_fail("write data was never accepted");
    end
    @(negedge aclk);
endtask

task automatic wait_bvalid();
    int n;
    n = 0;
    settle();
    while (!mem_bvalid && n < TIMEOUT) begin
        @(negedge aclk);
        settle();
        n++;
    end
    if (mem_bvalid) begin
        check_bit("mst_bvalid", mst_bvalid, 1'b1);
    end else begin
        timeout_fail("memory write response never came");
    end
    @(negedge aclk);
endtask

// One read per lane, each in its own block
task automatic read_lanes();
    int e0;
    e0 = errors;
    for (int l = 0; l < LANES && !hung; l++) begin
        issue_read(addr_t'(32'h0B0 + 32'h40 * l + 4 * l), 4'b0000);
    end
    if (!hung) begin
        wait_reads_done();
    end
    report_test("word extraction", e0);
endtask

// Only arcache bit 1 counts, other bits toggle against it
task automatic io_flag_order();
    int e0;
    e0 = errors;
    for (int k = 0; k < 6 && !hung; k++) begin
        issue_read(addr_t'(32'h300 + 20 * k), (k % 2 == 0) ? 4'b0010 : 4'b1101);
    end
    if (!hung) begin
        wait_reads_done();
    end
    report_test("io flag", e0);
endtask

task automatic outstanding_limit();
    int e0;
    e0 = errors;
    settle();
    hold_rd = 1'b1;
    @(negedge aclk);
    for (int k = 0; k < OSTD_NUM && !hung; k++) begin
        issue_read(addr_t'(32'h204 + 32'h30 * k), 4'b0000);
    end
    drive_ar(addr_t'(10'h3F8), 4'b0010);
    // Tag FIFO full, request must wait until a completion frees a slot
    for (int c = 0; c < 6 && !hung; c++) begin
        settle();
        check_bit("mst_arready", mst_arready, 1'b0);
        check_bit("mem_arvalid", mem_arvalid, 1'b0);
        if (c == 5) begin
            hold_rd = 1'b0;
        end
        @(negedge aclk);
    end
    if (!hung) begin
        finish_ar(addr_t'(10'h3F8));
    end
    if (!hung) begin
        wait_reads_done();
    end
    report_test("outstanding limit", e0);
endtask

task automatic aligned_write();
    int e0;
    e0 = errors;
    mst_awvalid = 1'b1;
    mst_awaddr  = addr_t'(10'h208);
    mst_wvalid  = 1'b1;
    mst_wdata   = 32'hCAFE_1234;
    mst_wstrb   = 4'b1011;
    settle();
    check_bit("mst_awready", mst_awready, 1'b1);
    check_bit("mst_wready", mst_wready, 1'b1);
    check_bit("mem_awvalid", mem_awvalid, 1'b1);
    check_bit("mem_wvalid", mem_wvalid, 1'b1);
    check_bit("mst_bvalid", mst_bvalid, 1'b0);
    check_word("mem_awaddr", word_t'(mem_awaddr), 32'h200);
    check_block("mem_wdata", mem_wdata, {4{32'hCAFE_1234}});
    check_strb("mem_wstrb", mem_wstrb, 16'h0B00);
    @(negedge aclk);
    mst_awvalid = 1'b0;
    mst_wvalid  = 1'b0;
    wait_bvalid();
    if (!hung) begin
        settle();
        check_bit("mst_bvalid", mst_bvalid, 1'b0);
        @(negedge aclk);
    end
    report_test("aligned write", e0);
endtask

// Two addresses queue their lanes while W is stalled
task automatic addr_ahead_of_data();
    int e0;
    e0 = errors;
    settle();
    stall_w = 1'b1;
    @(negedge aclk);
    send_aw(addr_t'(10'h184));
    if (!hung) begin
        send_aw(addr_t'(10'h26C));
    end
    mst_awvalid = 1'b0;
    mst_wvalid  = 1'b1;
    mst_wdata   = 32'h1111_AAAA;
    mst_wstrb   = 4'b0110;
    settle();
    check_bit("mst_wready", mst_wready, 1'b0);
    stall_w = 1'b0;
    @(negedge aclk);
    if (!hung) begin
        finish_w(32'h1111_AAAA, 4'b0110, lane_t'(1));
    end
    mst_wdata = 32'h2222_5555;
    mst_wstrb = 4'b1001;
    if (!hung) begin
        finish_w(32'h2222_5555, 4'b1001, lane_t'(3));
    end
    mst_wvalid = 1'b0;
    report_test("address ahead of data", e0);
endtask

/* tb/tb_cache_memctrl.sv */
////////////////////////////////////////////////////////////////////////////
// Testbench for the cache memory controller. The memory model always takes
// addresses, answers reads in order and has one stall switch per path.
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/10ps

module tb_cache_memctrl;

    import cmc_pkg::*;

    localparam int ADDR_W   = 10;
    localparam int OSTD_NUM = 4;
    // Longest single wait in cycles
    localparam int TIMEOUT  = 200;

    typedef logic [ADDR_W-1:0] addr_t;

    logic        aclk = 1'b0;
    logic        aresetn;
    logic        mst_arvalid, mst_arready, mst_rvalid, mst_rready, mst_rcache;
    logic [3:0]  mst_arcache;
    addr_t       mst_araddr, mst_raddr, mem_araddr, mst_awaddr, mem_awaddr;
    block_t      mst_rdata_blk, mem_rdata, mem_wdata;
    word_t       mst_rdata, mst_wdata;
    word_strb_t  mst_wstrb;
    block_strb_t mem_wstrb;
    logic        mst_awvalid, mst_awready, mst_wvalid, mst_wready, mst_bvalid, mst_bready;
    logic        mem_arvalid, mem_arready, mem_rvalid, mem_rready;
    logic        mem_awvalid, mem_awready, mem_wvalid, mem_wready, mem_bvalid, mem_bready;

    // Memory model state
    logic [31:0] lcg_state = 32'h6525_4fc9;
    addr_t       rd_q[$];
    int          delay_cnt;
    int          b_pending;
    logic        hold_rd;
    logic        stall_w;
    logic        ar_hs, r_hs, w_hs, b_hs;
    addr_t       ar_addr;

    // Scoreboard and counters
    addr_t       exp_addr[$];
    logic        exp_io[$];
    int          errors;
    int          checks;
    int          tests_run;
    int          tests_failed;
    logic        hung;

    cache_memctrl #(
        .ADDR_W   (ADDR_W),
        .OSTD_NUM (OSTD_NUM)
    ) u_dut (.*);

    always #10 aclk = ~aclk;

    ////////////////////////////////////////////////////////////////////////////
    // Memory model
    ////////////////////////////////////////////////////////////////////////////

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    // Lane i of a block holds its aligned address tagged with i
    function automatic word_t model_word(input addr_t addr, input int i);
        return 32'hC0D0_0000 | (word_t'(i) << 16) | word_t'(addr);
    endfunction

    function automatic block_t model_block(input addr_t addr);
        block_t blk;
        for (int i = 0; i < LANES; i++) begin
            blk[i*XLEN +: XLEN] = model_word(addr, i);
        end
        return blk;
    endfunction

    initial begin
        mem_arready = 1'b1;
        mem_awready = 1'b1;
        mem_rvalid  = 1'b0;
        mem_rdata   = '0;
        mem_wready  = 1'b0;
        mem_bvalid  = 1'b0;
        {ar_hs, r_hs, w_hs, b_hs} = 4'b0;
        ar_addr     = '0;
        delay_cnt   = 0;
        b_pending   = 0;
        forever begin
            @(negedge aclk);
            if (!aresetn) begin
                rd_q.delete();
                b_pending  = 0;
                mem_rvalid = 1'b0;
                mem_wready = 1'b0;
                mem_bvalid = 1'b0;
            end else begin
                // Retire the transfers of the last rising edge
                if (r_hs) begin
                    void'(rd_q.pop_front());
                    delay_cnt = int'(lcg_next() >> 30);
                end
                if (ar_hs) begin
                    if (rd_q.size() == 0) begin
                        delay_cnt = int'(lcg_next() >> 30);
                    end
                    rd_q.push_back(ar_addr);
                end
                if (w_hs) begin
                    b_pending++;
                end
                if (b_hs) begin
                    b_pending--;
                end
                if (delay_cnt > 0) begin
                    delay_cnt--;
                end
                mem_rvalid = !hold_rd && rd_q.size() != 0 && delay_cnt == 0;
                mem_rdata  = (rd_q.size() != 0) ? model_block(rd_q[0]) : '0;
                mem_wready = !stall_w;
                mem_bvalid = b_pending > 0;
            end
            // Outputs settled, note what the next rising edge transfers
            #1;
            ar_hs   = mem_arvalid && mem_arready;
            ar_addr = mem_araddr;
            r_hs    = mem_rvalid && mem_rready;
            w_hs    = mem_wvalid && mem_wready;
            b_hs    = mem_bvalid && mem_bready;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Compare tasks
    ////////////////////////////////////////////////////////////////////////////

    task automatic check_word(input string name, input word_t got, input word_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("MISMATCH at %0t: %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    task automatic check_block(input string name, input block_t got, input block_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("MISMATCH at %0t: %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    task automatic check_strb(input string name, input block_strb_t got,
                              input block_strb_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("MISMATCH at %0t: %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("MISMATCH at %0t: %s got %b expected %b", $time, name, got, exp);
        end
    endtask

    // Read completion against the oldest request
    task automatic observe_read();
        addr_t a;
        addr_t base;
        logic  io;
        if (mst_rvalid && mst_rready) begin
            if (exp_addr.size() == 0) begin
                errors++;
                $display("ERROR at %0t: read completion with no read outstanding", $time);
            end else begin
                a    = exp_addr.pop_front();
                io   = exp_io.pop_front();
                base = a & ~addr_t'(15);
                check_word("mst_raddr", word_t'(mst_raddr), word_t'(a));
                check_word("mst_rdata", mst_rdata,
                           model_word(base, int'(lane_t'(a >> OFFSET_LSB))));
                check_block("mst_rdata_blk", mst_rdata_blk, model_block(base));
                check_bit("mst_rcache", mst_rcache, io);
            end
        end
    endtask

    // Once per cycle, after the falling edge drive has settled
    task automatic settle();
        #2;
        observe_read();
    endtask

    task automatic timeout_fail(input string what);
        errors++;
        hung = 1'b1;
        $display("TIMEOUT at %0t: %s", $time, what);
    endtask

    task automatic report_test(input string name, input int start_errors);
        tests_run++;
        if (errors == start_errors) begin
            $display("[%0t] %s: PASS", $time, name);
        end else begin
            tests_failed++;
            $display("[%0t] %s: FAIL, %0d errors", $time, name, errors - start_errors);
        end
    endtask

    `include "tb_tests.svh"

    ////////////////////////////////////////////////////////////////////////////
    // Sequence
    ////////////////////////////////////////////////////////////////////////////

    initial begin
        {mst_arvalid, mst_awvalid, mst_wvalid} = 3'b0;
        mst_araddr   = '0;
        mst_arcache  = '0;
        mst_awaddr   = '0;
        mst_wdata    = '0;
        mst_wstrb    = '0;
        mst_rready   = 1'b1;
        mst_bready   = 1'b1;
        hold_rd      = 1'b0;
        stall_w      = 1'b0;
        errors       = 0;
        checks       = 0;
        tests_run    = 0;
        tests_failed = 0;
        hung         = 1'b0;
        aresetn      = 1'b0;
        repeat (2) @(posedge aclk);
        @(negedge aclk);
        aresetn = 1'b1;
        @(negedge aclk);
        read_lanes();
        if (!hung) begin
            io_flag_order();
        end
        if (!hung) begin
            outstanding_limit();
        end
        if (!hung) begin
            aligned_write();
        end
        if (!hung) begin
            addr_ahead_of_data();
        end
        $display("tests %0d, failed %0d, checks %0d, errors %0d",
                 tests_run, tests_failed, checks, errors);
        if (errors == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

/* project.f */
+incdir+tb
rtl/cmc_pkg.sv
rtl/fifo_if.sv
rtl/sync_fifo.sv
rtl/rd_channel.sv
rtl/wr_channel.sv
rtl/cache_memctrl.sv
tb/tb_cache_memctrl.sv

/* run.sh */
#!/bin/sh
# Compile and run the cache memory controller testbench with Verilator
set -e
rm -rf obj_dir
verilator --binary --timing --assert -j 0 --top-module tb_cache_memctrl -f project.f
status=0
./obj_dir/Vtb_cache_memctrl > sim.log 2>&1 || status=$?
cat sim.log
if grep -q "Simulation failed" sim.log; then
    exit 1
fi
if [ "$status" -ne 0 ]; then
    exit "$status"
fi
